/* build.f */
+incdir+testbench
src/router_pkg.sv
src/router_write_if.sv
src/router_decode.sv
src/router_parity_check.sv
src/router_port_fifo.sv
src/router_top.sv
testbench/router_tb.sv

/* Bender.yml */
package:
  name: router

sources:
  - files:
      - src/router_pkg.sv
      - src/router_write_if.sv
      - src/router_decode.sv
      - src/router_parity_check.sv
      - src/router_port_fifo.sv
      - src/router_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/router_tb.sv

/* testbench/router_tb_ref.svh */
// Router reference model and checks
`ifndef router_tb_ref_svh
`define router_tb_ref_svh

// XOR over every byte in the list
function automatic data_t xor_bytes(input data_t bytes[$]);
    data_t acc;
    int i;
    acc = '0;
    for (i = 0; i < bytes.size(); i++) begin
        acc = acc ^ bytes[i];
    end
    return acc;
endfunction

// Header, then payload from the random stream, then parity over both
function automatic void build_packet(input port_addr_t port, input length_t len,
                                     output data_t pkt[$]);
    int i;
    pkt = {};
    pkt.push_back({len, port});
    for (i = 0; i < int'(len); i++) begin
        pkt.push_back(data_t'($random(seed)));
    end
    pkt.push_back(xor_bytes(pkt));
endfunction

// One packet byte seen on an output port
task automatic check_data(input string test, input data_t expected, input data_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("error: %s expected %h actual %h", test, expected, actual));
    end
endtask

// Single bit status such as err, busy or vld_out
task automatic check_flag(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
        fail_run($sformatf("error: %s expected %b actual %b", test, expected, actual));
    end
endtask

`endif

/* testbench/router_tb.sv */
// Router testbench
`timescale 1ns/100ps

module router_tb import router_pkg::*; ();

    localparam int depth = 16;
    localparam int num_pkts = 11;
    localparam int hold_cycles = 20;

    logic clock;
    logic resetn;
    logic packet_valid;
    data_t data_in;
    logic [2:0] read_enb;
    wire [data_width-1:0] data_out [num_ports];
    wire [2:0] vld_out;
    wire err;
    wire busy;

    int seed = 3;
    string test_name = "reset";
    data_t exp_q [num_ports][$];
    logic exp_err = 1'b0;
    port_addr_t pkt_port [num_pkts];
    length_t pkt_len [num_pkts];
    bit pkt_bad [num_pkts];
    int cycle_count = 0;
    int cycle_limit = 0;
    int stall_count = 0;

    `include "router_tb_ref.svh"

    router_top #(
        .depth(depth)
    ) router_top_i (
        .clock(clock),
        .resetn(resetn),
        .packet_valid(packet_valid),
        .data_in(data_in),
        .read_enb_0(read_enb[0]),
        .read_enb_1(read_enb[1]),
        .read_enb_2(read_enb[2]),
        .data_out_0(data_out[0]),
        .data_out_1(data_out[1]),
        .data_out_2(data_out[2]),
        .vld_out_0(vld_out[0]),
        .vld_out_1(vld_out[1]),
        .vld_out_2(vld_out[2]),
        .err(err),
        .busy(busy)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    function automatic length_t random_length();
        return length_t'($unsigned($random(seed)) % 24);
    endfunction

    // Packet table and the cycle budget that follows from it
    task automatic plan_packets();
        int i;
        int total_bytes;
        for (i = 0; i < num_pkts; i++) begin
            pkt_len[i] = random_length();
            pkt_bad[i] = 1'b0;
        end
        for (i = 0; i < 3; i++) begin
            pkt_port[i] = port_addr_t'(i);
        end
        pkt_port[3] = 2'd1;
        pkt_len[3] = '0;
        pkt_port[4] = 2'd0;
        pkt_port[5] = 2'd2;
        pkt_bad[5] = 1'b1;
        // Invalid address right after the bad packet, err must hold
        pkt_port[6] = 2'd3;
        // Payload behind this header shows err cleared before its parity
        pkt_port[7] = 2'd1;
        pkt_len[7] = length_t'(5);
        pkt_port[8] = 2'd1;
        pkt_len[8] = length_t'(40);
        pkt_port[9] = 2'd3;
        pkt_len[9] = length_t'(10);
        pkt_port[10] = 2'd2;
        total_bytes = 0;
        for (i = 0; i < num_pkts; i++) begin
            total_bytes += int'(pkt_len[i]) + 2;
        end
        cycle_limit = 2 * (total_bytes + hold_cycles + depth + 8 * num_pkts + 3);
    endtask

    task automatic wait_edge();
        @(posedge clock);
        #2;
    endtask

    // Holds the byte until an edge where busy is low
    task automatic send_byte(input data_t value);
        packet_valid = 1'b1;
        data_in = value;
        @(posedge clock);
        while (busy) begin
            stall_count++;
            @(posedge clock);
        end
        #2;
    endtask

    task automatic run_packet(input int idx);
        data_t pkt[$];
        int i;
        build_packet(pkt_port[idx], pkt_len[idx], pkt);
        // The corrupted parity byte still lands in the port FIFO
        if (pkt_bad[idx]) begin
            pkt[pkt.size() - 1] = pkt[pkt.size() - 1] ^ 8'h5a;
        end
        if (pkt_port[idx] != 2'd3) begin
            for (i = 0; i < pkt.size(); i++) begin
                exp_q[pkt_port[idx]].push_back(pkt[i]);
            end
            exp_err = pkt_bad[idx];
        end
        for (i = 0; i < pkt.size(); i++) begin
            send_byte(pkt[i]);
            // A routed header has cleared err, and no parity byte has reached it yet
            if (i == 1 && pkt_port[idx] != 2'd3 && pkt_len[idx] != '0) begin
                check_flag({test_name, " err cleared by header"}, 1'b0, err);
            end
        end
        packet_valid = 1'b0;
        // err follows on the edge after the parity byte is taken
        wait_edge();
        check_flag({test_name, " err"}, exp_err, err);
    endtask

    task automatic wait_drained();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || exp_q[2].size() != 0) begin
            wait_edge();
        end
        check_flag({test_name, " vld_out idle"}, 1'b0, |vld_out);
    endtask

    // Compare process, one expected queue per port
    always @(posedge clock) begin
        if (resetn) begin
            for (int p = 0; p < num_ports; p++) begin
                if (vld_out[p] && exp_q[p].size() == 0) begin
                    fail_run($sformatf("port %0d shows a byte that no packet sent there", p));
                end else if (read_enb[p] && vld_out[p]) begin
                    check_data($sformatf("%s port %0d", test_name, p),
                               exp_q[p].pop_front(), data_out[p]);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, the router stopped moving data",
                               cycle_count));
        end
    end

    initial begin
        int i;
        packet_valid = 1'b0;
        data_in = '0;
        read_enb = '0;
        resetn = 1'b0;
        plan_packets();
        repeat (3) @(posedge clock);
        #2;
        resetn = 1'b1;
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset err", 1'b0, err);
        check_flag("reset vld_out", 1'b0, |vld_out);

        test_name = "routing";
        read_enb = 3'b111;
        for (i = 0; i < 4; i++) begin
            run_packet(i);
        end
        wait_drained();

        test_name = "parity";
        for (i = 4; i < 8; i++) begin
            run_packet(i);
        end
        wait_drained();

        // Port 1 is left unread until the sender has been held for a while
        test_name = "backpressure";
        read_enb = 3'b101;
        fork
            run_packet(8);
            begin
                while (!busy) begin
                    wait_edge();
                end
                repeat (hold_cycles) wait_edge();
                check_flag("backpressure busy held", 1'b1, busy);
                check_flag("backpressure vld_out_1", 1'b1, vld_out[1]);
                read_enb[1] = 1'b1;
            end
        join
        wait_drained();

        test_name = "discard";
        run_packet(9);
        repeat (4) begin
            wait_edge();
            check_flag("discard vld_out", 1'b0, |vld_out);
        end
        run_packet(10);
        wait_drained();

        $display("sender stalled for %0d cycles", stall_count);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* src/router_top.sv */
// 1x3 packet router
`timescale 1ns/100ps

module router_top import router_pkg::*; #(
    parameter int depth = 16
) (
    input  logic  clock,
    input  logic  resetn,
    input  logic  packet_valid,
    input  data_t data_in,
    input  logic  read_enb_0,
    input  logic  read_enb_1,
    input  logic  read_enb_2,
    output data_t data_out_0,
    output data_t data_out_1,
    output data_t data_out_2,
    output logic  vld_out_0,
    output logic  vld_out_1,
    output logic  vld_out_2,
    output logic  err,
    output logic  busy
);

    port_mask_t nearly_full;
    port_mask_t push;
    port_mask_t read_enb;
    port_mask_t vld_out;
    data_t push_data;
    data_t data_out [num_ports];

    router_write_if wr ();

    assign read_enb = {read_enb_2, read_enb_1, read_enb_0};

    router_decode decode_i (
        .clock(clock),
        .resetn(resetn),
        .packet_valid(packet_valid),
        .data_in(data_in),
        .nearly_full(nearly_full),
        .busy(busy),
        .wr(wr.decode_mp)
    );

    router_parity_check check_i (
        .clock(clock),
        .resetn(resetn),
        .wr(wr.check_mp),
        .push(push),
        .push_data(push_data),
        .err(err)
    );

    // One FIFO per output port
    for (genvar i = 0; i < num_ports; i++) begin : g_port
        router_port_fifo #(
            .depth(depth)
        ) fifo_i (
            .clock(clock),
            .resetn(resetn),
            .push(push[i]),
            .push_data(push_data),
            .pop(read_enb[i]),
            .head(data_out[i]),
            .not_empty(vld_out[i]),
            .nearly_full(nearly_full[i])
        );
    end

    assign data_out_0 = data_out[0];
    assign data_out_1 = data_out[1];
    assign data_out_2 = data_out[2];
    assign vld_out_0 = vld_out[0];
    assign vld_out_1 = vld_out[1];
    assign vld_out_2 = vld_out[2];

endmodule

/* src/router_port_fifo.sv */
// Output port FIFO
`timescale 1ns/100ps

module router_port_fifo import router_pkg::*; #(
    parameter int depth = 16
) (
    input  logic  clock,
    input  logic  resetn,
    input  logic  push,
    input  data_t push_data,
    input  logic  pop,
    output data_t head,
    output logic  not_empty,
    output logic  nearly_full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    typedef logic [ptr_width-1:0] ptr_t;

    data_t mem [depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic [count_width-1:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    // Pointers wrap at depth, which need not be a power of two
    function automatic ptr_t ptr_next(ptr_t ptr);
        if (ptr == ptr_t'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == count_width'(depth));
    assign do_push = push && !full;
    assign do_pop = pop && not_empty;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head byte shown without a read delay
    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);
    // One slot kept for the byte already in flight
    assign nearly_full = (count >= count_width'(depth - 1));

    a_no_overflow: assert property (@(posedge clock) disable iff (!resetn)
        full |-> !push);

endmodule

/* src/router_parity_check.sv */
// Parity check and port select
`timescale 1ns/100ps

module router_parity_check import router_pkg::*; (
    input  logic             clock,
    input  logic             resetn,
    router_write_if.check_mp wr,
    output port_mask_t       push,
    output data_t            push_data,
    output logic             err
);

    // Running XOR of header and payload
    data_t parity_q;

    always_ff @(posedge clock) begin
        if (wr.valid) begin
            case (wr.kind)
                kind_header: parity_q <= wr.data;
                kind_payload: parity_q <= parity_q ^ wr.data;
                default: parity_q <= parity_q;
            endcase
        end
    end

    // Error holds until the next routed header
    always_ff @(posedge clock) begin
        if (!resetn) begin
            err <= 1'b0;
        end else if (wr.valid && wr.kind == kind_header) begin
            err <= 1'b0;
        end else if (wr.valid && wr.kind == kind_parity) begin
            err <= (wr.data != parity_q);
        end
    end

    // Every byte of the packet goes to the same FIFO
    assign push = wr.valid ? port_onehot(wr.port) : '0;
    assign push_data = wr.data;

    a_push_onehot: assert property (@(posedge clock) disable iff (!resetn)
        $onehot0(push));

endmodule

/* src/router_decode.sv */
// Packet decode state machine
`timescale 1ns/100ps

module router_decode import router_pkg::*; (
    input  logic              clock,
    input  logic              resetn,
    input  logic              packet_valid,
    input  data_t             data_in,
    input  port_mask_t        nearly_full,
    output logic              busy,
    router_write_if.decode_mp wr
);

    decode_state_t state_q;
    decode_state_t state_d;
    port_addr_t    port_q;
    length_t       count_q;
    length_t       count_d;
    byte_kind_t    kind_d;
    port_addr_t    hdr_port;
    length_t       hdr_length;
    logic          accept;
    logic          keep;

    // Header fields
    assign hdr_port = data_in[1:0];
    assign hdr_length = data_in[data_width-1:2];

    // Stall while the target port has one free slot or less
    always_comb begin
        case (state_q)
            st_idle: busy = |nearly_full;
            st_payload, st_parity: busy = |(nearly_full & port_onehot(port_q));
            default: busy = 1'b0;
        endcase
    end

    assign accept = packet_valid && !busy;

    always_comb begin
        state_d = state_q;
        count_d = count_q;
        kind_d = kind_payload;
        keep = 1'b0;
        case (state_q)
            st_idle: begin
                kind_d = kind_header;
                keep = (port_onehot(hdr_port) != '0);
                if (accept) begin
                    count_d = hdr_length;
                    if (!keep) begin
                        state_d = st_discard;
                    end else if (hdr_length == '0) begin
                        state_d = st_parity;
                    end else begin
                        state_d = st_payload;
                    end
                end
            end
            st_payload: begin
                keep = 1'b1;
                if (accept) begin
                    count_d = count_q - 1'b1;
                    // Last payload byte, parity follows
                    if (count_q == length_t'(1)) begin
                        state_d = st_parity;
                    end
                end
            end
            st_parity: begin
                kind_d = kind_parity;
                keep = 1'b1;
                if (accept) begin
                    state_d = st_idle;
                end
            end
            st_discard: begin
                // Count covers the payload, the parity byte ends it
                if (accept) begin
                    if (count_q == '0) begin
                        state_d = st_idle;
                    end else begin
                        count_d = count_q - 1'b1;
                    end
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q <= st_idle;
            count_q <= '0;
            port_q <= '0;
            wr.valid <= 1'b0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
            if (state_q == st_idle && accept) begin
                port_q <= hdr_port;
            end
            wr.valid <= accept && keep;
        end
    end

    always_ff @(posedge clock) begin
        wr.data <= data_in;
        wr.kind <= kind_d;
        wr.port <= (state_q == st_idle) ? hdr_port : port_q;
    end

    a_state_legal: assert property (@(posedge clock) disable iff (!resetn)
        !$isunknown(state_q) && state_q inside {st_idle, st_payload, st_parity, st_discard});

    // Packets to address 3 never reach the check stage
    a_no_invalid_port: assert property (@(posedge clock) disable iff (!resetn)
        wr.valid |-> port_onehot(wr.port) != '0);

endmodule

/* src/router_write_if.sv */
// Decoded packet byte link
`timescale 1ns/100ps

interface router_write_if import router_pkg::*; ();

    // One byte per cycle, no back-pressure
    logic       valid;
    port_addr_t port;
    data_t      data;
    byte_kind_t kind;

    modport decode_mp (
        output valid,
        output port,
        output data,
        output kind
    );

    modport check_mp (
        input valid,
        input port,
        input data,
        input kind
    );

endinterface

/* src/router_pkg.sv */
// Router shared types
package router_pkg;

    // Packet byte and field widths
    parameter int data_width = 8;
    parameter int num_ports = 3;

    typedef logic [data_width-1:0] data_t;
    typedef logic [1:0] port_addr_t;
    typedef logic [data_width-3:0] length_t;
    typedef logic [num_ports-1:0] port_mask_t;

    // Which part of the packet a byte belongs to
    typedef enum logic [1:0] {
        kind_header,
        kind_payload,
        kind_parity
    } byte_kind_t;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_parity,
        st_discard
    } decode_state_t;

    // One-hot port select, all zero for the invalid address
    function automatic port_mask_t port_onehot(port_addr_t port);
        port_mask_t mask;
        int i;
        mask = '0;
        for (i = 0; i < num_ports; i++) begin
            if (port == port_addr_t'(i)) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

endpackage
